// File: verification/memory_slave_vectors.txt
# kind: W write to own id 5, R read from own id 5, X write frame to another slave id
# then bus address (15 bits, id in bits 14:12), write data, expected read data, all in hex
W 5000 a5 00
W 5fff ff 00
W 5123 7b 00
R 5000 00 a5
R 5fff 00 ff
X 2123 3c 00
R 5123 00 7b
W 5abc 09 00
X 7abc 64 00
R 5abc 00 09
W 5555 64 00
W 5aaa 0a 00
R 5555 00 64
R 5aaa 00 0a
X 4000 11 00
R 5000 00 a5
W 5000 c8 00
R 5000 00 c8
W 5001 99 00
X 6001 00 00
R 5001 00 99
R 5123 00 7b

// File: filelist.f
+incdir+common
common/bus_slave_pkg.sv
memory_slave/byte_ram.sv
memory_slave/memory_access_ctrl.sv
hdl/serial_frame_rx.sv
hdl/serial_reply_tx.sv
hdl/seg7_bcd_display.sv
hdl/memory_slave_top.sv
verification/tb_clock_gen.sv
verification/memory_slave_props.sv
verification/tb_memory_slave.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_memory_slave
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard common/*.svh)
VECTORS := verification/memory_slave_vectors.txt
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM) $(VECTORS)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf $(BUILD_DIR)

// File: verification/tb_memory_slave.sv
`include "bus_slave_settings.svh"

module tb_memory_slave;

    timeunit 1ns;
    timeprecision 1ps;

    localparam bus_slave_pkg::slave_id_t own_id = 3'd5;
    localparam int cycles_per_vector = 30;
    localparam int drive_delay       = 2;
    localparam int write_len  = 1 + `BS_ADDR_WIDTH + `BS_DATA_WIDTH;     // Start, addr, data.
    localparam int read_req   = 1 + `BS_ADDR_WIDTH;
    localparam int first_bit  = read_req + 2;                             // RAM plus load cycle.
    localparam int read_len   = first_bit + `BS_DATA_WIDTH;

    logic                clk;
    logic                rstn;
    logic                bus_util;
    logic                rd_wrt;
    logic                serial_in;
    logic                busy_out;
    logic                serial_out;
    logic                serial_oe;
    bus_slave_pkg::seg_t disp_out2;
    bus_slave_pkg::seg_t disp_out1;
    bus_slave_pkg::seg_t disp_out0;

    byte                      vec_kind [$];
    bus_slave_pkg::bus_addr_t vec_addr [$];
    bus_slave_pkg::bus_data_t vec_data [$];
    bus_slave_pkg::bus_data_t vec_exp  [$];
    bus_slave_pkg::bus_data_t model [bus_slave_pkg::mem_addr_t];
    bus_slave_pkg::bus_data_t last_byte;
    string                    test_label;
    int                       frame_cycle;
    int                       vec_errs;
    int                       load_errs;
    int                       tests_passed;
    int                       tests_failed;
    int                       cycle_cnt;
    int                       cycle_limit;

    tb_clock_gen #(.period_ns(20)) i_tb_clock_gen (.clk(clk));

    memory_slave_top #(.self_id(own_id)) i_memory_slave_top (
        .clk        (clk),
        .rstn       (rstn),
        .bus_util   (bus_util),
        .rd_wrt     (rd_wrt),
        .serial_in  (serial_in),
        .busy_out   (busy_out),
        .serial_out (serial_out),
        .serial_oe  (serial_oe),
        .disp_out2  (disp_out2),
        .disp_out1  (disp_out1),
        .disp_out0  (disp_out0)
    );

    // Standard gfedcba pattern of a decimal digit.
    function automatic bus_slave_pkg::seg_t digit_pattern(input int digit);
        case (digit)
            0:       return 7'h3f;
            1:       return 7'h06;
            2:       return 7'h5b;
            3:       return 7'h4f;
            4:       return 7'h66;
            5:       return 7'h6d;
            6:       return 7'h7d;
            7:       return 7'h07;
            8:       return 7'h7f;
            9:       return 7'h6f;
            default: return 7'h00;
        endcase
    endfunction

    function automatic logic frame_bit(input int j, input logic is_write,
                                       input bus_slave_pkg::bus_addr_t addr,
                                       input bus_slave_pkg::bus_data_t data);
        if (j >= 1 && j <= `BS_ADDR_WIDTH) return addr[j - 1];
        if (is_write && j > `BS_ADDR_WIDTH && j < write_len) return data[j - read_req];
        return 1'b0;
    endfunction

    task automatic report_mismatch(input string name, input logic [7:0] expected,
                                   input logic [7:0] actual);
        $display("FAIL %s: expected %h, got %h (%s, cycle %0d)",
                 name, expected, actual, test_label, frame_cycle);
        vec_errs++;
    endtask

    task automatic check_display(input bus_slave_pkg::bus_data_t shown);
        if (disp_out2 !== digit_pattern(shown / 100)) begin
            report_mismatch("disp_out2", digit_pattern(shown / 100), disp_out2);
        end
        if (disp_out1 !== digit_pattern((shown / 10) % 10)) begin
            report_mismatch("disp_out1", digit_pattern((shown / 10) % 10), disp_out1);
        end
        if (disp_out0 !== digit_pattern(shown % 10)) begin
            report_mismatch("disp_out0", digit_pattern(shown % 10), disp_out0);
        end
    endtask

    task automatic finish_test();
        if (vec_errs == 0) begin
            $display("%s: ok", test_label);
            tests_passed++;
        end else begin
            $display("%s: failed with %0d errors", test_label, vec_errs);
            tests_failed++;
        end
    endtask

    task automatic load_vectors();
        int                       fd;
        string                    line;
        byte                      kind;
        bus_slave_pkg::bus_addr_t addr;
        bus_slave_pkg::bus_data_t data;
        bus_slave_pkg::bus_data_t exp_rd;
        fd = $fopen("verification/memory_slave_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vectors file.");
            load_errs++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%c %h %h %h", kind, addr, data, exp_rd) == 4) begin
                        vec_kind.push_back(kind);
                        vec_addr.push_back(addr);
                        vec_data.push_back(data);
                        vec_exp.push_back(exp_rd);
                    end else begin
                        $display("Malformed line in the vectors file: %s", line);
                        load_errs++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_frame(input int idx);
        byte                      kind;
        bus_slave_pkg::bus_addr_t addr;
        bus_slave_pkg::bus_data_t data;
        bus_slave_pkg::bus_data_t exp_rd;
        bus_slave_pkg::bus_data_t rx_byte;
        bus_slave_pkg::bus_data_t shown_new;
        bus_slave_pkg::mem_addr_t mem_idx;
        logic                     is_write;
        logic                     own;
        logic                     exp_busy;
        logic                     exp_oe;
        int                       frame_len;
        int                       upd_cycle;
        kind      = vec_kind[idx];
        addr      = vec_addr[idx];
        data      = vec_data[idx];
        exp_rd    = vec_exp[idx];
        mem_idx   = addr[`BS_MEM_ADDR_WIDTH-1:0];
        own       = (kind != "X");
        is_write  = (kind != "R");
        frame_len = is_write ? write_len : read_len;
        upd_cycle = is_write ? write_len + 1 : first_bit;                 // Register plus one.
        shown_new = !own ? last_byte : (is_write ? data : exp_rd);
        rx_byte   = '0;
        vec_errs  = 0;
        test_label = $sformatf("vector %0d %c %h", idx, kind, addr);
        if (kind != "W" && kind != "R" && kind != "X") begin
            $display("%s: unknown transaction kind", test_label);
            vec_errs++;
        end
        if (own != (addr[`BS_ADDR_WIDTH-1 -: `BS_ID_WIDTH] == own_id)) begin
            $display("%s: slave id field does not fit the kind", test_label);
            vec_errs++;
        end
        if (kind == "R" && !model.exists(mem_idx)) begin
            $display("%s: reads an address that was never written", test_label);
            vec_errs++;
        end else if (kind == "R" && model[mem_idx] != exp_rd) begin
            $display("%s: expected data disagrees with the memory model", test_label);
            vec_errs++;
        end
        for (int j = 0; j < frame_len + 2; j++) begin
            @(posedge clk);
            #(drive_delay);
            bus_util    = (j < frame_len);
            rd_wrt      = (j == 0) ? is_write : 1'b0;
            serial_in   = frame_bit(j, is_write, addr, data);
            @(negedge clk);
            frame_cycle = j;
            exp_busy = own && (is_write ? (j == write_len) : (j >= read_req && j < read_len));
            exp_oe   = own && !is_write && j >= first_bit && j < read_len;
            if (busy_out !== exp_busy) report_mismatch("busy_out", exp_busy, busy_out);
            if (serial_oe !== exp_oe) report_mismatch("serial_oe", exp_oe, serial_oe);
            if (exp_oe) begin
                rx_byte[j - first_bit] = serial_out;                      // LSB first.
            end else if (serial_out !== 1'b0) begin
                report_mismatch("serial_out", 8'h00, serial_out);
            end
            check_display((own && j >= upd_cycle) ? shown_new : last_byte);
        end
        if (own && !is_write && rx_byte !== exp_rd) begin
            report_mismatch("serial_out", exp_rd, rx_byte);
        end
        if (own && is_write) model[mem_idx] = data;
        last_byte = shown_new;
        finish_test();
    endtask

    initial begin : main
        rstn         = 1'b0;
        bus_util     = 1'b0;
        rd_wrt       = 1'b0;
        serial_in    = 1'b0;
        last_byte    = '0;
        load_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        load_vectors();
        cycle_limit = vec_kind.size() * cycles_per_vector + 100;
        repeat (8) @(posedge clk);
        #(drive_delay);
        rstn = 1'b1;
        @(negedge clk);
        test_label  = "after reset";
        frame_cycle = 0;
        vec_errs    = 0;
        if (busy_out !== 1'b0) report_mismatch("busy_out", 8'h00, busy_out);
        if (serial_oe !== 1'b0) report_mismatch("serial_oe", 8'h00, serial_oe);
        if (serial_out !== 1'b0) report_mismatch("serial_out", 8'h00, serial_out);
        check_display(8'd0);
        finish_test();
        for (int i = 0; i < vec_kind.size(); i++) begin
            run_frame(i);
        end
        if (vec_kind.size() == 0) $display("No vectors were loaded.");
        $display("Tests: %0d run, %0d passed, %0d failed, %0d file errors",
                 tests_passed + tests_failed, tests_passed, tests_failed, load_errs);
        if (tests_failed == 0 && load_errs == 0 && vec_kind.size() != 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        cycle_cnt = 0;
        wait (cycle_limit != 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles.", cycle_limit);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: verification/memory_slave_props.sv
module memory_slave_props (
    input logic clk,
    input logic rstn,
    input logic bus_util,
    input logic busy_out,
    input logic serial_oe
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [3:0] oe_len;                                                   // High cycles so far.

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            oe_len <= '0;
        end else if (serial_oe) begin
            oe_len <= oe_len + 4'd1;
        end else begin
            oe_len <= '0;
        end
    end

    oe_needs_busy: assert property (@(posedge clk) disable iff (!rstn)
        serial_oe |-> busy_out)
        else $error("serial_oe high while busy_out is low");

    oe_burst_max: assert property (@(posedge clk) disable iff (!rstn)
        serial_oe |-> (oe_len < 4'd8))
        else $error("serial_oe burst longer than 8 cycles");

    // A burst that just ended must have lasted exactly 8 cycles.
    oe_burst_len: assert property (@(posedge clk) disable iff (!rstn)
        (!serial_oe && oe_len != 4'd0) |-> (oe_len == 4'd8))
        else $error("serial_oe burst shorter than 8 cycles");

    idle_not_busy: assert property (@(posedge clk) disable iff (!rstn)
        (!bus_util && !$past(bus_util)) |-> !busy_out)
        else $error("busy_out high after two idle bus cycles");

endmodule

bind memory_slave_top memory_slave_props i_memory_slave_props (
    .clk       (clk),
    .rstn      (rstn),
    .bus_util  (bus_util),
    .busy_out  (busy_out),
    .serial_oe (serial_oe)
);

// File: verification/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int period_ns = 20
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;                              // Rises at half period.
    end

endmodule

// File: hdl/memory_slave_top.sv
module memory_slave_top #(
    parameter bus_slave_pkg::slave_id_t self_id = '0
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                bus_util,
    input  logic                rd_wrt,
    input  logic                serial_in,
    output logic                busy_out,
    output logic                serial_out,
    output logic                serial_oe,
    output bus_slave_pkg::seg_t disp_out2,
    output bus_slave_pkg::seg_t disp_out1,
    output bus_slave_pkg::seg_t disp_out0
);

    logic                     req_valid;
    logic                     req_write;
    bus_slave_pkg::mem_addr_t req_addr;
    bus_slave_pkg::bus_data_t req_data;
    logic                     tx_load;
    bus_slave_pkg::bus_data_t tx_data;
    logic                     tx_done;
    bus_slave_pkg::bus_data_t shown_byte;

    serial_frame_rx #(
        .self_id (self_id)
    ) i_serial_frame_rx (
        .clk       (clk),
        .rstn      (rstn),
        .bus_util  (bus_util),
        .rd_wrt    (rd_wrt),
        .serial_in (serial_in),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_data  (req_data)
    );

    memory_access_ctrl i_memory_access_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_data   (req_data),
        .tx_done    (tx_done),
        .busy_out   (busy_out),
        .tx_load    (tx_load),
        .tx_data    (tx_data),
        .shown_byte (shown_byte)
    );

    serial_reply_tx i_serial_reply_tx (
        .clk        (clk),
        .rstn       (rstn),
        .tx_load    (tx_load),
        .tx_data    (tx_data),
        .serial_out (serial_out),
        .serial_oe  (serial_oe),
        .tx_done    (tx_done)
    );

    seg7_bcd_display i_seg7_bcd_display (
        .value     (shown_byte),
        .disp_out2 (disp_out2),
        .disp_out1 (disp_out1),
        .disp_out0 (disp_out0)
    );

endmodule

// File: hdl/seg7_bcd_display.sv
`include "bus_slave_settings.svh"

module seg7_bcd_display (
    input  bus_slave_pkg::bus_data_t value,
    output bus_slave_pkg::seg_t      disp_out2,
    output bus_slave_pkg::seg_t      disp_out1,
    output bus_slave_pkg::seg_t      disp_out0
);

    logic [3:0] hundreds;
    logic [3:0] tens;
    logic [3:0] ones;

    function automatic bus_slave_pkg::seg_t digit_to_seg(input logic [3:0] digit);
        case (digit)
            4'd0:    return 7'h3f;
            4'd1:    return 7'h06;
            4'd2:    return 7'h5b;
            4'd3:    return 7'h4f;
            4'd4:    return 7'h66;
            4'd5:    return 7'h6d;
            4'd6:    return 7'h7d;
            4'd7:    return 7'h07;
            4'd8:    return 7'h7f;
            4'd9:    return 7'h6f;
            default: return 7'h00;                                        // Blank.
        endcase
    endfunction

    // Shift-and-add-3 over the input bits, MSB first.
    always_comb begin : dabble
        logic [11:0] bcd;
        bcd = '0;
        for (int i = `BS_DATA_WIDTH - 1; i >= 0; i--) begin
            if (bcd[3:0] > 4'd4) bcd[3:0] = bcd[3:0] + 4'd3;
            if (bcd[7:4] > 4'd4) bcd[7:4] = bcd[7:4] + 4'd3;
            if (bcd[11:8] > 4'd4) bcd[11:8] = bcd[11:8] + 4'd3;
            bcd = {bcd[10:0], value[i]};
        end
        hundreds = bcd[11:8];
        tens     = bcd[7:4];
        ones     = bcd[3:0];
    end

    assign disp_out2 = digit_to_seg(hundreds);
    assign disp_out1 = digit_to_seg(tens);
    assign disp_out0 = digit_to_seg(ones);

endmodule

// File: hdl/serial_reply_tx.sv
`include "bus_slave_settings.svh"

module serial_reply_tx (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     tx_load,
    input  bus_slave_pkg::bus_data_t tx_data,
    output logic                     serial_out,
    output logic                     serial_oe,
    output logic                     tx_done
);

    localparam int cnt_w = $clog2(`BS_DATA_WIDTH);
    localparam logic [cnt_w-1:0] last_bit = cnt_w'(`BS_DATA_WIDTH - 1);

    bus_slave_pkg::bus_data_t shift_q;
    logic [cnt_w-1:0]         bit_cnt;
    logic                     oe_q;
    logic                     done_q;

    assign serial_out = oe_q & shift_q[0];                                // Idle line is 0.
    assign serial_oe  = oe_q;
    assign tx_done    = done_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            oe_q    <= 1'b0;
            bit_cnt <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (tx_load) begin
                oe_q    <= 1'b1;
                bit_cnt <= '0;
            end else if (oe_q) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == last_bit) begin
                    oe_q   <= 1'b0;
                    done_q <= 1'b1;                                       // One-cycle pulse.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_load) begin
            shift_q <= tx_data;
        end else if (oe_q) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

// File: hdl/serial_frame_rx.sv
`include "bus_slave_settings.svh"

module serial_frame_rx #(
    parameter bus_slave_pkg::slave_id_t self_id = '0
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     bus_util,
    input  logic                     rd_wrt,
    input  logic                     serial_in,
    output logic                     req_valid,
    output logic                     req_write,
    output bus_slave_pkg::mem_addr_t req_addr,
    output bus_slave_pkg::bus_data_t req_data
);

    localparam int cnt_w = $clog2(`BS_ADDR_WIDTH);
    localparam logic [cnt_w-1:0] addr_last = cnt_w'(`BS_ADDR_WIDTH - 1);
    localparam logic [cnt_w-1:0] data_last = cnt_w'(`BS_DATA_WIDTH - 1);

    bus_slave_pkg::rx_state_t state;
    logic [cnt_w-1:0]         bit_cnt;
    logic                     is_write;
    logic                     id_match;
    bus_slave_pkg::bus_addr_t addr_sr;
    bus_slave_pkg::bus_addr_t addr_next;
    bus_slave_pkg::bus_data_t data_sr;

    assign addr_next = {serial_in, addr_sr[`BS_ADDR_WIDTH-1:1]};          // LSB first.
    assign id_match  = (addr_next[`BS_ADDR_WIDTH-1 -: `BS_ID_WIDTH] == self_id);

    assign req_write = is_write;
    assign req_addr  = addr_sr[`BS_MEM_ADDR_WIDTH-1:0];
    assign req_data  = data_sr;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= bus_slave_pkg::rx_idle;
            bit_cnt   <= '0;
            is_write  <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            req_valid <= 1'b0;
            case (state)
                bus_slave_pkg::rx_idle: begin
                    if (bus_util) begin                                   // Start cycle.
                        state    <= bus_slave_pkg::rx_addr;
                        bit_cnt  <= '0;
                        is_write <= rd_wrt;
                    end
                end
                bus_slave_pkg::rx_addr: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (!bus_util) begin
                        state <= bus_slave_pkg::rx_idle;                  // Aborted frame.
                    end else if (bit_cnt == addr_last) begin
                        bit_cnt <= '0;
                        if (!id_match) begin
                            state <= bus_slave_pkg::rx_skip;
                        end else if (is_write) begin
                            state <= bus_slave_pkg::rx_data;
                        end else begin
                            req_valid <= 1'b1;
                            state     <= bus_slave_pkg::rx_skip;          // Reply phase.
                        end
                    end
                end
                bus_slave_pkg::rx_data: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (!bus_util) begin
                        state <= bus_slave_pkg::rx_idle;
                    end else if (bit_cnt == data_last) begin
                        req_valid <= 1'b1;
                        state     <= bus_slave_pkg::rx_skip;
                    end
                end
                bus_slave_pkg::rx_skip: begin
                    if (!bus_util) state <= bus_slave_pkg::rx_idle;        // Frame over.
                end
                default: state <= bus_slave_pkg::rx_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == bus_slave_pkg::rx_addr) addr_sr <= addr_next;
        if (state == bus_slave_pkg::rx_data) data_sr <= {serial_in, data_sr[`BS_DATA_WIDTH-1:1]};
    end

endmodule

// File: memory_slave/memory_access_ctrl.sv
module memory_access_ctrl (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     req_valid,
    input  logic                     req_write,
    input  bus_slave_pkg::mem_addr_t req_addr,
    input  bus_slave_pkg::bus_data_t req_data,
    input  logic                     tx_done,
    output logic                     busy_out,
    output logic                     tx_load,
    output bus_slave_pkg::bus_data_t tx_data,
    output bus_slave_pkg::bus_data_t shown_byte
);

    bus_slave_pkg::ctrl_state_t state;
    logic                       ram_we;
    bus_slave_pkg::mem_addr_t   ram_addr;
    bus_slave_pkg::bus_data_t   ram_wdata;
    bus_slave_pkg::bus_data_t   ram_rdata;

    // Writes complete in the request cycle itself.
    assign ram_we    = req_valid & req_write;
    assign ram_addr  = req_addr;
    assign ram_wdata = req_data;

    assign tx_load = (state == bus_slave_pkg::ctrl_read_wait);            // rdata valid now.
    assign tx_data = ram_rdata;

    assign busy_out = req_valid
                    | (state == bus_slave_pkg::ctrl_read_wait)
                    | ((state == bus_slave_pkg::ctrl_replying) & ~tx_done);

    byte_ram i_byte_ram (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= bus_slave_pkg::ctrl_idle;
            shown_byte <= '0;                                             // Display "000".
        end else begin
            case (state)
                bus_slave_pkg::ctrl_idle: begin
                    if (req_valid && !req_write) state <= bus_slave_pkg::ctrl_read_wait;
                end
                bus_slave_pkg::ctrl_read_wait: begin
                    state <= bus_slave_pkg::ctrl_replying;
                end
                bus_slave_pkg::ctrl_replying: begin
                    if (tx_done) state <= bus_slave_pkg::ctrl_idle;
                end
                default: state <= bus_slave_pkg::ctrl_idle;
            endcase

            if (ram_we) begin
                shown_byte <= req_data;
            end else if (tx_load) begin
                shown_byte <= ram_rdata;
            end
        end
    end

endmodule

// File: memory_slave/byte_ram.sv
`include "bus_slave_settings.svh"

module byte_ram (
    input  logic                     clk,
    input  logic                     we,
    input  bus_slave_pkg::mem_addr_t addr,
    input  bus_slave_pkg::bus_data_t wdata,
    output bus_slave_pkg::bus_data_t rdata
);

    localparam int depth = 1 << `BS_MEM_ADDR_WIDTH;

    bus_slave_pkg::bus_data_t mem [0:depth-1];

    // Read returns the old contents on a same-address write.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// File: common/bus_slave_pkg.sv
`include "bus_slave_settings.svh"

package bus_slave_pkg;

    typedef logic [`BS_ADDR_WIDTH-1:0]     bus_addr_t;
    typedef logic [`BS_DATA_WIDTH-1:0]     bus_data_t;
    typedef logic [`BS_MEM_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [`BS_ID_WIDTH-1:0]       slave_id_t;
    typedef logic [`BS_SEG_WIDTH-1:0]      seg_t;      // gfedcba, active high.

    // Frame receiver states.
    typedef enum logic [1:0] {
        rx_idle,
        rx_addr,
        rx_data,
        rx_skip                                        // Rest of frame ignored.
    } rx_state_t;

    // Access controller states.
    typedef enum logic [1:0] {
        ctrl_idle,
        ctrl_read_wait,                                // RAM read latency.
        ctrl_replying
    } ctrl_state_t;

endpackage

// File: common/bus_slave_settings.svh
`ifndef BUS_SLAVE_SETTINGS_SVH
`define BUS_SLAVE_SETTINGS_SVH

// Serial bus frame layout.
`define BS_ADDR_WIDTH     15
`define BS_DATA_WIDTH     8
`define BS_ID_WIDTH       3

// Slave memory.
`define BS_MEM_ADDR_WIDTH 12

// Display.
`define BS_SEG_WIDTH      7

`endif
